//--- Makefile
# Verilator simulation of the block-to-row reorder testbench

VERILATOR ?= verilator
TOP       ?= b2r_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/b2r_converter.sv
//******************************
// Block-to-row sequencer
// Fill, slice load, output and done phases
//******************************
module b2r_converter
    import b2r_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  full,
    input  logic                  loaded,
    input  logic [ROW_W-1:0]      row_data,
    output logic                  fill_en,
    output logic                  load_req,
    output logic [ADDR_W-1:0]     slice_base,
    output logic                  emit,
    output logic [PAIR_IDX_W-1:0] pair_idx,
    output logic                  row_valid,
    output out_row_t              row,
    output logic                  slice_done,
    output logic                  frame_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,
        ST_LOAD,
        ST_OUT,
        ST_DONE
    } state_t;

    state_t             state;
    logic [SLICE_W-1:0] slice_cnt;
    logic               last_pair;
    logic               last_slice;

    assign last_pair  = (pair_idx == PAIR_IDX_W'(PAIRS_PER_WORD - 1));
    assign last_slice = (slice_cnt == SLICE_W'(NUM_SLICES - 1));

    // Each slice starts SLICE_ROWS words further into the buffer
    assign slice_base = ADDR_W'(slice_cnt) * ADDR_W'(SLICE_ROWS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            fill_en    <= 1'b0;
            load_req   <= 1'b0;
            emit       <= 1'b0;
            pair_idx   <= '0;
            slice_cnt  <= '0;
            row_valid  <= 1'b0;
            slice_done <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            load_req   <= 1'b0;
            // A row leaves one cycle after its pair is selected
            row_valid  <= emit;
            slice_done <= emit && last_pair;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_FILL;
                        fill_en <= 1'b1;
                    end
                end
                ST_FILL: begin
                    if (full) begin
                        state     <= ST_LOAD;
                        fill_en   <= 1'b0;
                        load_req  <= 1'b1;
                        slice_cnt <= '0;
                    end
                end
                ST_LOAD: begin
                    if (loaded) begin
                        state    <= ST_OUT;
                        emit     <= 1'b1;
                        pair_idx <= '0;
                    end
                end
                ST_OUT: begin
                    if (emit) begin
                        if (last_pair) begin
                            emit <= 1'b0;
                        end else begin
                            pair_idx <= pair_idx + 1'b1;
                        end
                    end else if (last_slice) begin
                        // Final row is out
                        state      <= ST_DONE;
                        frame_done <= 1'b1;
                    end else begin
                        state     <= ST_LOAD;
                        load_req  <= 1'b1;
                        slice_cnt <= slice_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    // Next start begins a new frame
                    if (start) begin
                        state      <= ST_FILL;
                        fill_en    <= 1'b1;
                        frame_done <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Row payload with its slice and row position
    always_ff @(posedge clk) begin
        if (emit) begin
            row <= '{data: row_data, slice_idx: slice_cnt, row_idx: pair_idx};
        end
    end

    // Slice buffer reports a finished load only while one is pending
    a_loaded_in_load: assert property (
        @(posedge clk) disable iff (!rst_n) loaded |-> (state == ST_LOAD)
    ) else $error("slice loaded outside the load phase");

endmodule

//--- logic/b2r_pkg.sv
//******************************
// Block-to-row reorder package
// Geometry, buffer word and row types
//******************************
package b2r_pkg;

    // Element and core geometry
    localparam int ELEM_W         = 8;
    localparam int PAIR           = 2;
    localparam int NUM_CORES      = 2;
    localparam int CHUNK_SIZE     = 4;
    localparam int WORD_ELEMS     = NUM_CORES * CHUNK_SIZE;
    localparam int PAIRS_PER_WORD = WORD_ELEMS / PAIR;
    localparam int PAIR_W         = PAIR * ELEM_W;

    // Slice and buffer geometry
    localparam int SLICE_ROWS     = 4;
    localparam int NUM_SLICES     = 2;
    localparam int DEPTH          = SLICE_ROWS * NUM_SLICES;
    localparam int ADDR_W         = $clog2(DEPTH);
    localparam int ROW_W          = SLICE_ROWS * PAIR_W;

    // Counter widths
    localparam int PAIR_IDX_W     = $clog2(PAIRS_PER_WORD);
    localparam int LOAD_W         = $clog2(SLICE_ROWS);
    localparam int SLICE_W        = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    // One buffer word, written per core lane and read per element pair
    typedef union packed {
        logic [0:NUM_CORES-1][CHUNK_SIZE-1:0][ELEM_W-1:0] lanes;
        // Pair 0 sits in the top bits
        logic [0:PAIRS_PER_WORD-1][PAIR-1:0][ELEM_W-1:0]  pairs;
    } buffer_word_u;

    // RAM write port
    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        buffer_word_u      data;
    } ram_wr_t;

    // One reordered output row with its position in the frame
    typedef struct packed {
        logic [ROW_W-1:0]      data;
        logic [SLICE_W-1:0]    slice_idx;
        logic [PAIR_IDX_W-1:0] row_idx;
    } out_row_t;

endpackage

//--- logic/b2r_top.sv
//******************************
// Block-to-row reorder top level
//******************************
module b2r_top
    import b2r_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic         in_valid,
    input  buffer_word_u in_word,
    output logic         row_valid,
    output out_row_t     row,
    output logic         slice_done,
    output logic         frame_done
);

    ram_wr_t               wr;
    logic                  full;
    logic                  fill_en;
    logic                  load_req;
    logic [ADDR_W-1:0]     slice_base;
    logic [ADDR_W-1:0]     rd_addr;
    buffer_word_u          rd_data;
    logic                  loaded;
    logic                  emit;
    logic [PAIR_IDX_W-1:0] pair_idx;
    logic [ROW_W-1:0]      row_data;

    b2r_converter u_converter (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .full       (full),
        .loaded     (loaded),
        .row_data   (row_data),
        .fill_en    (fill_en),
        .load_req   (load_req),
        .slice_base (slice_base),
        .emit       (emit),
        .pair_idx   (pair_idx),
        .row_valid  (row_valid),
        .row        (row),
        .slice_done (slice_done),
        .frame_done (frame_done)
    );

    fill_ctrl u_fill (
        .clk      (clk),
        .rst_n    (rst_n),
        .fill_en  (fill_en),
        .in_valid (in_valid),
        .in_word  (in_word),
        .wr       (wr),
        .full     (full)
    );

    slice_buffer u_slice (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .slice_base (slice_base),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .loaded     (loaded),
        .emit       (emit),
        .pair_idx   (pair_idx),
        .row_data   (row_data)
    );

    ram_1w1r u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- logic/fill_ctrl.sv
//******************************
// Fill controller
// Writes input words to sequential RAM addresses
//******************************
module fill_ctrl
    import b2r_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         fill_en,
    input  logic         in_valid,
    input  buffer_word_u in_word,
    output ram_wr_t      wr,
    output logic         full
);

    logic [ADDR_W-1:0] wr_cnt;
    logic              filled;
    logic              accept;
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    buffer_word_u      data_q;

    // Strobes are dropped outside the fill phase and once the buffer holds DEPTH words
    assign accept = fill_en && in_valid && !filled;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
            filled <= 1'b0;
            we_q   <= 1'b0;
            full   <= 1'b0;
        end else begin
            we_q <= accept;
            full <= 1'b0;
            if (!fill_en) begin
                wr_cnt <= '0;
                filled <= 1'b0;
            end else if (accept) begin
                if (wr_cnt == ADDR_W'(DEPTH - 1)) begin
                    // Hold at the last address
                    filled <= 1'b1;
                    full   <= 1'b1;
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= wr_cnt;
            data_q <= in_word;
        end
    end

    assign wr = '{we: we_q, addr: addr_q, data: data_q};

    // Source must stop once full is reported
    a_no_input_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) (fill_en && filled) |-> !in_valid
    ) else $error("in_valid after buffer full");

endmodule

//--- logic/ram_1w1r.sv
//******************************
// Buffer RAM, one write and one read port
// Read data arrives one cycle after the address
//******************************
module ram_1w1r
    import b2r_pkg::*;
(
    input  logic              clk,
    input  ram_wr_t           wr,
    input  logic [ADDR_W-1:0] rd_addr,
    output buffer_word_u      rd_data
);

    buffer_word_u mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    a_wr_addr_range: assert property (
        @(posedge clk) wr.we |-> (!$isunknown(wr.addr) && (int'(wr.addr) < DEPTH))
    ) else $error("RAM write address out of range");

endmodule

//--- logic/slice_buffer.sv
//******************************
// Slice buffer
// Loads one slice from RAM, builds output rows
//******************************
module slice_buffer
    import b2r_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_req,
    input  logic [ADDR_W-1:0]     slice_base,
    output logic [ADDR_W-1:0]     rd_addr,
    input  buffer_word_u          rd_data,
    output logic                  loaded,
    input  logic                  emit,
    input  logic [PAIR_IDX_W-1:0] pair_idx,
    output logic [ROW_W-1:0]      row_data
);

    logic                          rd_active;
    logic [LOAD_W-1:0]             rd_cnt;
    logic [ADDR_W-1:0]             rd_ptr;
    logic                          cap_vld;
    logic [LOAD_W-1:0]             cap_idx;
    buffer_word_u                  words [SLICE_ROWS];
    logic [0:SLICE_ROWS-1][PAIR_W-1:0] row_cat;

    // Read issue side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active <= 1'b0;
            rd_cnt    <= '0;
            rd_ptr    <= '0;
            cap_vld   <= 1'b0;
            cap_idx   <= '0;
        end else begin
            // Capture index trails the read index by the RAM latency
            cap_vld <= rd_active;
            cap_idx <= rd_cnt;
            if (load_req) begin
                rd_active <= 1'b1;
                rd_cnt    <= '0;
                rd_ptr    <= slice_base;
            end else if (rd_active) begin
                if (rd_cnt == LOAD_W'(SLICE_ROWS - 1)) begin
                    rd_active <= 1'b0;
                end
                rd_cnt <= rd_cnt + 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign rd_addr = rd_ptr;

    always_ff @(posedge clk) begin
        if (cap_vld) begin
            words[cap_idx] <= rd_data;
        end
    end

    // Last word is on rd_data and lands at this edge
    assign loaded = cap_vld && (cap_idx == LOAD_W'(SLICE_ROWS - 1));

    // Pair k of every slice word, word 0 on top
    always_comb begin
        for (int j = 0; j < SLICE_ROWS; j++) begin
            row_cat[j] = emit ? words[j].pairs[pair_idx] : '0;
        end
    end

    assign row_data = row_cat;

    // Converter must not restart or read a slice while it is still loading
    a_no_overlap_load: assert property (
        @(posedge clk) disable iff (!rst_n) (load_req || emit) |-> !(rd_active || cap_vld)
    ) else $error("slice access during load");

endmodule

//--- sim.f
logic/b2r_pkg.sv
logic/ram_1w1r.sv
logic/fill_ctrl.sv
logic/slice_buffer.sv
logic/b2r_converter.sv
logic/b2r_top.sv
verification/clk_gen.sv
verification/b2r_tb.sv

//--- verification/b2r_tb.sv
//******************************
// Block-to-row reorder testbench
// Two LFSR frames with rows checked by ordering rule
//******************************
module b2r_tb
    import b2r_pkg::*;
();

    localparam int NUM_FRAMES   = 2;
    localparam int DRIVE_DLY    = 2;
    localparam int IDLE_CYCLES  = 3;
    localparam int WORD_W       = WORD_ELEMS * ELEM_W;
    localparam int FRAME_ROWS   = NUM_SLICES * PAIRS_PER_WORD;
    localparam int FRAME_CYCLES = 3 * IDLE_CYCLES + DEPTH + 6
                                  + NUM_SLICES * (SLICE_ROWS + PAIRS_PER_WORD + 4);
    localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + 50;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         in_valid;
    buffer_word_u in_word;
    logic         row_valid;
    out_row_t     row;
    logic         slice_done;
    logic         frame_done;

    logic [WORD_W-1:0] stim    [NUM_FRAMES][DEPTH];
    logic [ROW_W-1:0]  exp_row [NUM_FRAMES][NUM_SLICES][PAIRS_PER_WORD];
    logic [15:0]       lfsr;
    int                err_count;
    int                check_count;
    int                cycle_count;
    int                cur_frame;
    int                rows_seen;
    logic              idle_expected;
    logic              prev_slice_done;
    logic              prev_frame_done;

    clk_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    b2r_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .row_valid  (row_valid),
        .row        (row),
        .slice_done (slice_done),
        .frame_done (frame_done)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {fb, s[15:1]};
    endfunction

    function automatic logic [WORD_W-1:0] next_word();
        logic [WORD_W-1:0] w;
        for (int b = 0; b < WORD_W; b++) begin
            w[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return w;
    endfunction

    // Pair 0 is the top PAIR_W bits of a word
    function automatic logic [PAIR_W-1:0] pair_of(input logic [WORD_W-1:0] w, input int k);
        return w[WORD_W - 1 - k * PAIR_W -: PAIR_W];
    endfunction

    task automatic build_tables();
        logic [ROW_W-1:0] r;
        lfsr = 16'd19487;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int a = 0; a < DEPTH; a++) begin
                stim[f][a] = next_word();
            end
        end
        // Row k of slice s takes pair k of each slice word with the first word on top
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int s = 0; s < NUM_SLICES; s++) begin
                for (int k = 0; k < PAIRS_PER_WORD; k++) begin
                    r = '0;
                    for (int j = 0; j < SLICE_ROWS; j++) begin
                        r = {r[ROW_W-PAIR_W-1:0], pair_of(stim[f][s * SLICE_ROWS + j], k)};
                    end
                    exp_row[f][s][k] = r;
                end
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [ROW_W-1:0] exp_val,
                                   input logic [ROW_W-1:0] act_val);
        err_count++;
        $display("ERR %s: expected %0h, actual %0h", name, exp_val, act_val);
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("Error at cycle %0d: %s", cycle_count, what);
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Strobes the DUT must ignore
    task automatic stray_strobes(input int n);
        for (int i = 0; i < n; i++) begin
            in_valid = 1'b1;
            in_word  = next_word();
            step();
        end
        in_valid = 1'b0;
    endtask

    task automatic check_row();
        int    s;
        int    k;
        string name;
        s = rows_seen / PAIRS_PER_WORD;
        k = rows_seen % PAIRS_PER_WORD;
        name = $sformatf("frame%0d slice%0d row%0d", cur_frame, s, k);
        check_count++;
        if (rows_seen >= FRAME_ROWS) begin
            report_error("more output rows than the frame holds");
        end else begin
            if (row.slice_idx !== SLICE_W'(s) || row.row_idx !== PAIR_IDX_W'(k)) begin
                report_mismatch({name, " index"}, ROW_W'(s * PAIRS_PER_WORD + k),
                                ROW_W'({row.slice_idx, row.row_idx}));
            end
            if (row.data !== exp_row[cur_frame][s][k]) begin
                report_mismatch({name, " data"}, exp_row[cur_frame][s][k], row.data);
            end
            if (slice_done !== 1'(k == PAIRS_PER_WORD - 1)) begin
                report_mismatch({name, " slice_done"}, ROW_W'(k == PAIRS_PER_WORD - 1),
                                ROW_W'(slice_done));
            end
        end
        rows_seen++;
    endtask

    // Outputs sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (idle_expected && (row_valid || slice_done || frame_done)) begin
                report_error("outputs active after reset before start");
            end
            if (row_valid) begin
                check_row();
            end else if (slice_done) begin
                report_error("slice_done without an output row");
            end
            if (frame_done && !prev_frame_done) begin
                check_count++;
                if (!prev_slice_done || rows_seen != FRAME_ROWS) begin
                    report_error("frame_done rose without the final slice just done");
                end
            end
            prev_slice_done = slice_done;
            prev_frame_done = frame_done;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: frame did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d  Errors: %0d", check_count, err_count + 1);
            $display("Test failed");
            $finish;
        end
    end

    task automatic run_frame(input int f);
        cur_frame = f;
        rows_seen = 0;
        stray_strobes(IDLE_CYCLES);
        idle_expected = 1'b0;
        start = 1'b1;
        step();
        start = 1'b0;
        for (int a = 0; a < DEPTH; a++) begin
            in_valid = 1'b1;
            in_word  = stim[f][a];
            step();
        end
        in_valid = 1'b0;
        // Let the fill phase close before more strobes
        step();
        step();
        stray_strobes(IDLE_CYCLES);
        while (frame_done !== 1'b1) begin
            step();
        end
        check_count++;
        if (rows_seen != FRAME_ROWS) begin
            report_mismatch($sformatf("frame%0d row count", f), ROW_W'(FRAME_ROWS),
                            ROW_W'(rows_seen));
        end
        repeat (IDLE_CYCLES) begin
            step();
            if (frame_done !== 1'b1) begin
                report_error("frame_done dropped before the next start");
            end
        end
    endtask

    initial begin
        start           = 1'b0;
        in_valid        = 1'b0;
        in_word         = '0;
        err_count       = 0;
        check_count     = 0;
        cycle_count     = 0;
        cur_frame       = 0;
        rows_seen       = 0;
        idle_expected   = 1'b1;
        prev_slice_done = 1'b0;
        prev_frame_done = 1'b0;
        build_tables();
        wait (rst_n === 1'b1);
        step();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        $display("Checks: %0d  Errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- verification/clk_gen.sv
//******************************
// Testbench clock and reset
// Reset held low for a fixed number of cycles
//******************************
module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule
